//--- build.f
hdl/mipsPkg.sv
hdl/ctrlIf.sv
hdl/instDecoder.sv
hdl/regFile.sv
hdl/execUnit.sv
hdl/pcUnit.sv
hdl/mipsCore.sv
tests/clkGen.sv
tests/mipsCore_chk.sv
tests/mipsCoreTb.sv

//--- Bender.yml
package:
  name: mipsCore

sources:
  - hdl/mipsPkg.sv
  - hdl/ctrlIf.sv
  - hdl/instDecoder.sv
  - hdl/regFile.sv
  - hdl/execUnit.sv
  - hdl/pcUnit.sv
  - hdl/mipsCore.sv
  - target: test
    files:
      - tests/clkGen.sv
      - tests/mipsCore_chk.sv
      - tests/mipsCoreTb.sv

//--- tests/mipsCoreTb.sv
module mipsCoreTb import mipsPkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD = 40;
  localparam int N_RAND = 60;
  // fixed tail of jal, store, load, two beqs, j and the final self jump
  localparam int PROG_LEN = N_RAND + 11;
  localparam int END_IDX = N_RAND + 8;
  localparam int SUB_IDX = N_RAND + 9;

  // expected effects of one instruction
  typedef struct packed {
    word_t     nextPc;
    logic      wbEn;
    regIdx_t   wbAddr;
    word_t     wbData;
    logic      memWe;
    dataAddr_t memAddr;
    word_t     memData;
  } expect_t;

  logic      clk;
  logic      rst;
  word_t     instAddr;
  word_t     inst;
  dataAddr_t dataAddr;
  word_t     dataWdata;
  logic      dataWe;
  word_t     dataRdata;
  logic      wbEn;
  regIdx_t   wbAddr;
  word_t     wbData;

  word_t progMem [PROG_LEN];
  word_t dataMem [DATA_WORDS];
  // shadow state of the reference model
  word_t shadowRegs [32];
  word_t shadowMem [DATA_WORDS];
  word_t shadowPc;
  int    valueErrors = 0;
  int    otherErrors = 0;

  clkGen uClk (.clk(clk), .rst(rst));

  mipsCore dut (.*);

  bind mipsCore mipsCore_chk uChk (.*);

  // ====================
  // memory models
  // ====================

  // past the program every fetch is a no-op
  always_comb begin
    if (instAddr[31:2] < PROG_LEN) inst = progMem[instAddr[31:2]];
    else inst = '0;
  end

  assign dataRdata = dataMem[dataAddr];

  always @(posedge clk) begin
    if (dataWe) dataMem[dataAddr] <= dataWdata;
  end

  // ====================
  // encoders
  // ====================

  function automatic word_t encR(logic [5:0] fn, regIdx_t rs, regIdx_t rt, regIdx_t rd);
    return {6'h00, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic word_t encI(logic [5:0] op, regIdx_t rs, regIdx_t rt, logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic word_t encJ(logic [5:0] op, logic [25:0] target);
    return {op, target};
  endfunction

  // ====================
  // reference model
  // ====================

  function automatic word_t readReg(regIdx_t idx);
    return (idx == '0) ? '0 : shadowRegs[idx];
  endfunction

  function automatic expect_t refStep(word_t pc, word_t ins);
    expect_t e;
    word_t   rsv;
    word_t   rtv;
    word_t   imm;
    word_t   pc4;
    word_t   addr;
    rsv = readReg(ins[25:21]);
    rtv = readReg(ins[20:16]);
    imm = {{16{ins[15]}}, ins[15:0]};
    pc4 = pc + 32'd4;
    e = '0;
    e.nextPc = pc4;
    case (ins[31:26])
      OP_RTYPE: begin
        e.wbAddr = ins[15:11];
        e.wbEn = 1'b1;
        case (ins[5:0])
          FN_ADD: e.wbData = rsv + rtv;
          FN_SUB: e.wbData = rsv - rtv;
          FN_AND: e.wbData = rsv & rtv;
          FN_OR:  e.wbData = rsv | rtv;
          FN_SLT: e.wbData = ($signed(rsv) < $signed(rtv)) ? 32'd1 : 32'd0;
          FN_JR: begin
            e.wbEn = 1'b0;
            e.nextPc = rsv;
          end
          default: e.wbEn = 1'b0;
        endcase
      end
      OP_LW: begin
        addr = rsv + imm;
        e.wbEn = 1'b1;
        e.wbAddr = ins[20:16];
        e.wbData = shadowMem[addr[8:2]];
      end
      OP_SW: begin
        addr = rsv + imm;
        e.memWe = 1'b1;
        e.memAddr = addr[8:2];
        e.memData = rtv;
      end
      OP_BEQ: begin
        if (rsv == rtv) e.nextPc = pc4 + (imm << 2);
      end
      OP_J: e.nextPc = {pc4[31:28], ins[25:0], 2'b00};
      OP_JAL: begin
        e.nextPc = {pc4[31:28], ins[25:0], 2'b00};
        e.wbEn = 1'b1;
        e.wbAddr = regIdx_t'(LINK_REG);
        e.wbData = pc4;
      end
      default: ;
    endcase
    return e;
  endfunction

  // ====================
  // compare tasks
  // ====================

  task automatic checkPc(word_t actual, word_t expected);
    if (actual !== expected) begin
      $display("Fail instAddr: got %h expected %h", actual, expected);
      valueErrors++;
    end
  endtask

  task automatic checkWb(logic en, regIdx_t addr, word_t data, expect_t e);
    if (en !== e.wbEn) begin
      $display("Fail wbEn: got %h expected %h", en, e.wbEn);
      valueErrors++;
    end else if (e.wbEn) begin
      if (addr !== e.wbAddr) begin
        $display("Fail wbAddr: got %h expected %h", addr, e.wbAddr);
        valueErrors++;
      end
      if (data !== e.wbData) begin
        $display("Fail wbData: got %h expected %h", data, e.wbData);
        valueErrors++;
      end
    end
  endtask

  task automatic checkMem(logic we, dataAddr_t addr, word_t data, expect_t e);
    if (we !== e.memWe) begin
      $display("Fail dataWe: got %h expected %h", we, e.memWe);
      valueErrors++;
    end else if (e.memWe) begin
      if (addr !== e.memAddr) begin
        $display("Fail dataAddr: got %h expected %h", addr, e.memAddr);
        valueErrors++;
      end
      if (data !== e.memData) begin
        $display("Fail dataWdata: got %h expected %h", data, e.memData);
        valueErrors++;
      end
    end
  endtask

  // ====================
  // program and data
  // ====================

  initial begin
    int kind;
    logic [5:0] fn;
    void'($urandom(32'hd3694dca));
    for (int i = 0; i < DATA_WORDS; i++) begin
      dataMem[i] = $urandom;
      shadowMem[i] = dataMem[i];
    end
    for (int i = 0; i < 32; i++) shadowRegs[i] = '0;
    shadowPc = RESET_PC;
    for (int i = 0; i < N_RAND; i++) begin
      kind = $urandom_range(0, 9);
      case ($urandom_range(0, 4))
        0: fn = FN_ADD;
        1: fn = FN_SUB;
        2: fn = FN_AND;
        3: fn = FN_OR;
        default: fn = FN_SLT;
      endcase
      // destinations avoid r0 while sources may be r0
      if (kind <= 3 || kind == 9) begin
        progMem[i] = encR(fn, regIdx_t'($urandom_range(0, 31)),
                          regIdx_t'($urandom_range(0, 31)),
                          regIdx_t'($urandom_range(1, 31)));
      end else if (kind <= 5) begin
        progMem[i] = encI(OP_LW, regIdx_t'($urandom_range(0, 31)),
                          regIdx_t'($urandom_range(1, 31)),
                          16'($urandom_range(0, 127) << 2));
      end else if (kind <= 7) begin
        progMem[i] = encI(OP_SW, regIdx_t'($urandom_range(0, 31)),
                          regIdx_t'($urandom_range(0, 31)),
                          16'($urandom_range(0, 127) << 2));
      end else if ($urandom_range(0, 1) == 0) begin
        // addi is outside the subset
        progMem[i] = encI(6'h08, 5'd1, 5'd2, 16'h1234);
      end else begin
        progMem[i] = encR(6'h00, 5'd3, 5'd4, 5'd5);
      end
    end
    // call first so r31 holds a known nonzero link
    progMem[N_RAND + 0] = encJ(OP_JAL, SUB_IDX);
    // store the link and load it back
    progMem[N_RAND + 1] = encI(OP_SW, 5'd0, 5'd31, 16'h0000);
    progMem[N_RAND + 2] = encI(OP_LW, 5'd0, 5'd7, 16'h0000);
    // taken beq skips the add
    progMem[N_RAND + 3] = encI(OP_BEQ, 5'd0, 5'd0, 16'h0001);
    progMem[N_RAND + 4] = encR(FN_ADD, 5'd7, 5'd7, 5'd8);
    // r7 holds the nonzero link so this beq falls through
    progMem[N_RAND + 5] = encI(OP_BEQ, 5'd7, 5'd0, 16'h0001);
    progMem[N_RAND + 6] = encJ(OP_J, END_IDX);
    progMem[N_RAND + 7] = encR(FN_ADD, 5'd7, 5'd7, 5'd9);
    progMem[END_IDX] = encJ(OP_J, END_IDX);
    // subroutine copies the link and returns
    progMem[SUB_IDX] = encR(FN_OR, 5'd31, 5'd0, 5'd10);
    progMem[SUB_IDX + 1] = encR(FN_JR, 5'd31, 5'd0, 5'd0);
  end

  // ====================
  // compare process
  // ====================

  initial begin
    expect_t e;
    int endHits;
    endHits = 0;
    while (endHits < 2) begin
      @(negedge clk);
      // mid low phase where all combinational paths have settled
      #(CLK_PERIOD / 4);
      if (!rst) begin
        if (dataWe !== 1'b0 || wbEn !== 1'b0) begin
          $display("write strobe active while reset is held");
          otherErrors++;
        end
      end else begin
        checkPc(instAddr, shadowPc);
        e = refStep(shadowPc, progMem[shadowPc[31:2]]);
        checkWb(wbEn, wbAddr, wbData, e);
        checkMem(dataWe, dataAddr, dataWdata, e);
        if (e.wbEn && e.wbAddr != '0) shadowRegs[e.wbAddr] = e.wbData;
        if (e.memWe) shadowMem[e.memAddr] = e.memData;
        if (shadowPc == END_IDX * 4) endHits++;
        shadowPc = e.nextPc;
      end
    end
    otherErrors += dut.uChk.assertFails;
    $display("errors: %0d wrong values, %0d other", valueErrors, otherErrors);
    if (valueErrors + otherErrors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // ====================
  // watchdog
  // ====================

  initial begin
    #((PROG_LEN + 20) * CLK_PERIOD);
    $display("timeout, the program never reached its final jump");
    otherErrors += dut.uChk.assertFails + 1;
    $display("errors: %0d wrong values, %0d other", valueErrors, otherErrors);
    $display("Simulation failed");
    $finish;
  end

endmodule

//--- tests/mipsCore_chk.sv
module mipsCore_chk import mipsPkg::*; (
  input logic    clk,
  input logic    rst,
  input logic    dataWe,
  input logic    wbEn,
  input regIdx_t wbAddr,
  input word_t   instAddr
);

  timeunit 1ns;
  timeprecision 100ps;

  // count of assertion failures
  int assertFails = 0;

  // no state writes while reset is held
  noWriteInReset: assert property (@(posedge clk) !rst |-> (!dataWe && !wbEn))
    else begin
      $error("memory or register write during reset");
      assertFails++;
    end

  // r0 never shows up as a writeback target
  noWriteToZero: assert property (@(posedge clk) disable iff (!rst) wbEn |-> (wbAddr != '0))
    else begin
      $error("writeback to register 0");
      assertFails++;
    end

  // fetch address on word boundary
  pcAligned: assert property (@(posedge clk) disable iff (!rst) instAddr[1:0] == 2'b00)
    else begin
      $error("instruction address not word aligned");
      assertFails++;
    end

  // first fetch out of reset
  firstFetch: assert property (@(posedge clk) $rose(rst) |-> (instAddr == RESET_PC))
    else begin
      $error("first fetch after reset not at reset address");
      assertFails++;
    end

endmodule

//--- tests/clkGen.sv
module clkGen (
  output logic clk,
  output logic rst
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int HALF_PERIOD = 20;
  localparam int RESET_CYCLES = 4;

  // free running 40 ns clock
  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

  // reset low for four cycles, released on a falling edge
  initial begin
    rst = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b1;
  end

endmodule

//--- hdl/mipsCore.sv
module mipsCore import mipsPkg::*; (
  input  logic      clk,
  input  logic      rst,
  output word_t     instAddr,
  input  word_t     inst,
  output dataAddr_t dataAddr,
  output word_t     dataWdata,
  output logic      dataWe,
  input  word_t     dataRdata,
  output logic      wbEn,
  output regIdx_t   wbAddr,
  output word_t     wbData
);

  // decoded control levels
  ctrlIf ctrlBus ();

  // register read data
  word_t rsData;
  word_t rtData;
  logic  branchTaken;
  // return address for jal
  word_t pcPlus4;

  // ====================
  // decode
  // ====================

  instDecoder uDecoder (
    .rst  (rst),
    .inst (inst),
    .ctrl (ctrlBus.dec)
  );

  // ====================
  // registers
  // ====================

  // rs and rt come straight from the instruction word
  regFile uRegFile (
    .clk      (clk),
    .rst      (rst),
    .regWrite (ctrlBus.regWrite),
    .rsIdx    (inst[25:21]),
    .rtIdx    (inst[20:16]),
    .wrIdx    (wbAddr),
    .wrData   (wbData),
    .rsData   (rsData),
    .rtData   (rtData)
  );

  // ====================
  // execute
  // ====================

  execUnit uExec (
    .inst        (inst),
    .ctrl        (ctrlBus.exe),
    .rsData      (rsData),
    .rtData      (rtData),
    .pcPlus4     (pcPlus4),
    .dataRdata   (dataRdata),
    .dataAddr    (dataAddr),
    .dataWdata   (dataWdata),
    .dataWe      (dataWe),
    .branchTaken (branchTaken),
    .wrIdx       (wbAddr),
    .wrData      (wbData)
  );

  // ====================
  // fetch
  // ====================

  // rs value doubles as the jr target
  pcUnit uPc (
    .clk         (clk),
    .rst         (rst),
    .inst        (inst),
    .ctrl        (ctrlBus.pc),
    .branchTaken (branchTaken),
    .jrTarget    (rsData),
    .pc          (instAddr),
    .pcPlus4     (pcPlus4)
  );

  // observation of the register write port
  assign wbEn = ctrlBus.regWrite;

endmodule

//--- hdl/pcUnit.sv
module pcUnit import mipsPkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  word_t inst,
  ctrlIf.pc     ctrl,
  input  logic  branchTaken,
  input  word_t jrTarget,
  output word_t pc,
  output word_t pcPlus4
);

  word_t pcReg;
  word_t pcNext;
  // pc-relative branch destination
  word_t branchTarget;
  // pseudo-direct jump destination
  word_t jumpTarget;

  // ====================
  // target formation
  // ====================

  assign pcPlus4 = pcReg + 32'd4;
  // offset is in words, sign-extend then shift by 2
  assign branchTarget = pcPlus4 + {{14{inst[15]}}, inst[15:0], 2'b00};
  // keep the 256 MB region of pc+4
  assign jumpTarget = {pcPlus4[31:28], inst[25:0], 2'b00};

  // jr over j/jal over beq over sequential
  always_comb begin
    if (ctrl.jumpReg) begin
      pcNext = jrTarget;
    end else if (ctrl.jump) begin
      pcNext = jumpTarget;
    end else if (branchTaken) begin
      pcNext = branchTarget;
    end else begin
      pcNext = pcPlus4;
    end
  end

  // ====================
  // pc register
  // ====================

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pcReg <= RESET_PC;
    end else begin
      pcReg <= pcNext;
    end
  end

  assign pc = pcReg;

endmodule

//--- hdl/execUnit.sv
module execUnit import mipsPkg::*; (
  input  word_t     inst,
  ctrlIf.exe        ctrl,
  input  word_t     rsData,
  input  word_t     rtData,
  input  word_t     pcPlus4,
  input  word_t     dataRdata,
  output dataAddr_t dataAddr,
  output word_t     dataWdata,
  output logic      dataWe,
  output logic      branchTaken,
  output regIdx_t   wrIdx,
  output word_t     wrData
);

  // sign-extended 16-bit immediate
  word_t immExt;
  // second alu operand
  word_t aluB;
  word_t aluResult;
  logic  aluZero;

  // ====================
  // operand select
  // ====================

  assign immExt = {{16{inst[15]}}, inst[15:0]};
  // lw/sw take the offset, everything else rt
  assign aluB = ctrl.aluSrc ? immExt : rtData;

  // ====================
  // alu
  // ====================

  always_comb begin
    case (ctrl.aluOp)
      ALU_ADD: aluResult = rsData + aluB;
      ALU_SUB: aluResult = rsData - aluB;
      ALU_AND: aluResult = rsData & aluB;
      ALU_OR:  aluResult = rsData | aluB;
      // signed compare
      ALU_SLT: aluResult = word_t'($signed(rsData) < $signed(aluB));
      default: aluResult = rsData + aluB;
    endcase
  end

  assign aluZero = (aluResult == '0);

  // beq taken when rs - rt is zero
  assign branchTaken = ctrl.branch & aluZero;

  // ====================
  // data memory
  // ====================

  // word address, byte offset dropped
  assign dataAddr = aluResult[8:2];
  // sw stores rt
  assign dataWdata = rtData;
  assign dataWe = ctrl.memWrite;

  // ====================
  // writeback
  // ====================

  // r31 for jal, rd for r-type, else rt
  assign wrIdx = ctrl.link   ? regIdx_t'(LINK_REG) :
                 ctrl.regDst ? inst[15:11] :
                               inst[20:16];

  // return address, load data or alu result
  assign wrData = ctrl.link     ? pcPlus4 :
                  ctrl.memToReg ? dataRdata :
                                  aluResult;

endmodule

//--- hdl/regFile.sv
module regFile import mipsPkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  logic    regWrite,
  input  regIdx_t rsIdx,
  input  regIdx_t rtIdx,
  input  regIdx_t wrIdx,
  input  word_t   wrData,
  output word_t   rsData,
  output word_t   rtData
);

  // general purpose registers
  word_t regs [REG_COUNT];

  // ====================
  // write port
  // ====================

  // async clear, writes on the rising edge
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 0; i < REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (regWrite && (wrIdx != '0)) begin
      // r0 is hardwired, drop writes to it
      regs[wrIdx] <= wrData;
    end
  end

  // ====================
  // read ports
  // ====================

  // combinational, r0 reads as zero
  assign rsData = (rsIdx == '0) ? '0 : regs[rsIdx];
  assign rtData = (rtIdx == '0) ? '0 : regs[rtIdx];

endmodule

//--- hdl/instDecoder.sv
module instDecoder import mipsPkg::*; (
  input  logic  rst,
  input  word_t inst,
  ctrlIf.dec    ctrl
);

  opcode_e opcode;
  funct_e  funct;
  // write enables before reset gating
  logic    regWriteRaw;
  logic    memWriteRaw;

  // ====================
  // field extraction
  // ====================

  assign opcode = opcode_e'(inst[31:26]);
  // only meaningful for r-type
  assign funct = funct_e'(inst[5:0]);

  // ====================
  // control decode
  // ====================

  always_comb begin
    // defaults are a no-op
    ctrl.regDst   = 1'b0;
    ctrl.aluSrc   = 1'b0;
    ctrl.memToReg = 1'b0;
    ctrl.branch   = 1'b0;
    ctrl.jump     = 1'b0;
    ctrl.link     = 1'b0;
    ctrl.jumpReg  = 1'b0;
    ctrl.aluOp    = ALU_ADD;
    regWriteRaw   = 1'b0;
    memWriteRaw   = 1'b0;
    case (opcode)
      OP_RTYPE: begin
        // rd is the destination for all alu functs
        ctrl.regDst = 1'b1;
        case (funct)
          FN_ADD: begin
            ctrl.aluOp  = ALU_ADD;
            regWriteRaw = 1'b1;
          end
          FN_SUB: begin
            ctrl.aluOp  = ALU_SUB;
            regWriteRaw = 1'b1;
          end
          FN_AND: begin
            ctrl.aluOp  = ALU_AND;
            regWriteRaw = 1'b1;
          end
          FN_OR: begin
            ctrl.aluOp  = ALU_OR;
            regWriteRaw = 1'b1;
          end
          FN_SLT: begin
            ctrl.aluOp  = ALU_SLT;
            regWriteRaw = 1'b1;
          end
          // jr redirects fetch, no writeback
          FN_JR: ctrl.jumpReg = 1'b1;
          // unknown funct falls through as a no-op
          default: ;
        endcase
      end
      OP_LW: begin
        // base + offset
        ctrl.aluSrc   = 1'b1;
        ctrl.memToReg = 1'b1;
        regWriteRaw   = 1'b1;
      end
      OP_SW: begin
        ctrl.aluSrc = 1'b1;
        memWriteRaw = 1'b1;
      end
      OP_BEQ: begin
        // equal when the difference is zero
        ctrl.aluOp  = ALU_SUB;
        ctrl.branch = 1'b1;
      end
      OP_J: ctrl.jump = 1'b1;
      OP_JAL: begin
        ctrl.jump   = 1'b1;
        ctrl.link   = 1'b1;
        regWriteRaw = 1'b1;
      end
      default: ;
    endcase
  end

  // no state changes while reset is held
  assign ctrl.regWrite = regWriteRaw & rst;
  assign ctrl.memWrite = memWriteRaw & rst;

endmodule

//--- hdl/ctrlIf.sv
interface ctrlIf import mipsPkg::*; ();

  // write index from rd instead of rt
  logic   regDst;
  // second alu operand is the immediate
  logic   aluSrc;
  // writeback from data memory
  logic   memToReg;
  logic   regWrite;
  logic   memWrite;
  // beq
  logic   branch;
  // j / jal
  logic   jump;
  // jal, write pc+4 to r31
  logic   link;
  // jr
  logic   jumpReg;
  aluOp_e aluOp;

  // decoder drives everything
  modport dec (
    output regDst, aluSrc, memToReg, regWrite, memWrite,
    output branch, jump, link, jumpReg, aluOp
  );

  // execute side
  modport exe (input aluSrc, aluOp, memToReg, memWrite, branch, link, regDst);

  // next-pc side
  modport pc (input jump, jumpReg);

endinterface

//--- hdl/mipsPkg.sv
package mipsPkg;

  // ====================
  // sizes
  // ====================

  // datapath width
  localparam int WORD_W = 32;
  // register file depth
  localparam int REG_COUNT = 32;
  // data memory depth in words
  localparam int DATA_WORDS = 128;
  // jal destination register
  localparam int LINK_REG = 31;
  // fetch address out of reset
  localparam logic [WORD_W-1:0] RESET_PC = '0;

  // ====================
  // basic types
  // ====================

  typedef logic [WORD_W-1:0] word_t;
  typedef logic [$clog2(REG_COUNT)-1:0] regIdx_t;
  // word address into data memory, address bits 8..2
  typedef logic [$clog2(DATA_WORDS)-1:0] dataAddr_t;

  // ====================
  // instruction fields
  // ====================

  // primary opcode, inst[31:26]
  typedef enum logic [5:0] {
    OP_RTYPE = 6'h00,
    OP_J     = 6'h02,
    OP_JAL   = 6'h03,
    OP_BEQ   = 6'h04,
    OP_LW    = 6'h23,
    OP_SW    = 6'h2b
  } opcode_e;

  // funct field of r-type, inst[5:0]
  typedef enum logic [5:0] {
    FN_JR  = 6'h08,
    FN_ADD = 6'h20,
    FN_SUB = 6'h22,
    FN_AND = 6'h24,
    FN_OR  = 6'h25,
    FN_SLT = 6'h2a
  } funct_e;

  // alu operation, merged from main control and alu control
  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_SLT = 3'd4
  } aluOp_e;

endpackage
